/* hdl/ej32_settings.svh */
/* core widths and return-stack size, shared by package and top level
   EJ32_RS_DEPTH must be a power of two, entry 0 is never written */
`ifndef EJ32_SETTINGS_SVH
`define EJ32_SETTINGS_SVH

// data path
`define EJ32_DSZ      32        // TOS and return-stack word

// instruction space
`define EJ32_ASZ      16        // byte address, 64K program memory

// return stack
`define EJ32_RS_DEPTH 32        // entries incl. the unused slot 0

`endif

/* hdl/ej32_pkg.sv */
/* types for the branch slice; opcodes follow JVM encodings where they exist,
   eForth ops sit in free codes, anything unlisted executes as nop */
`include "ej32_settings.svh"

package ej32_pkg;

    typedef logic [`EJ32_DSZ-1:0]                data_t;   // TOS / RS word
    typedef logic [`EJ32_ASZ-1:0]                addr_t;   // byte address
    typedef logic [$clog2(`EJ32_RS_DEPTH)-1:0]   rsp_t;    // RS pointer

    // phase count, 0 and 1 are the operand bytes
    typedef logic [1:0] phase_t;
    localparam phase_t PH_FETCH = 2'd3;                    // opcode byte on bus

    typedef enum logic [7:0] {
        nop           = 8'h00,
        ifeq          = 8'h99,
        ifne          = 8'h9A,
        iflt          = 8'h9B,
        ifge          = 8'h9C,
        ifgt          = 8'h9D,
        ifle          = 8'h9E,
        goto          = 8'hA7,
        jreturn       = 8'hB1,
        invokevirtual = 8'hB6,
        donext        = 8'hCA,                             // eForth loop
        dupr          = 8'hCB,                             // R@
        popr          = 8'hCC,                             // R>
        pushr         = 8'hCD                              // >R
    } opcode_t;

    // return-stack action of one cycle
    typedef enum logic [1:0] {
        s_nop,
        s_push,                                            // write rp+1, rp++
        s_pop,                                             // rp--, no write
        s_move                                             // overwrite top
    } stack_op_t;

endpackage

/* hdl/ej32_core_if.sv */
/* decoded instruction state from sequencer to branch unit, plus the TOS write path
   code is the bus byte itself during fetch, the latched opcode otherwise */
`timescale 1ns/1ns

interface ej32_core_if;
    import ej32_pkg::*;

    opcode_t    code;           // current opcode
    phase_t     phase;          // operand phase or PH_FETCH
    addr_t      ip;             // instruction pointer
    logic [7:0] ibyte;          // byte on program bus
    data_t      tos;            // top of data stack

    // TOS write request, taken on the next running edge
    logic       tos_we;
    data_t      tos_wdata;

    modport seq (
        output code,
        output phase,
        output ip,
        output ibyte,
        output tos,
        input  tos_we,
        input  tos_wdata
    );

    modport br (
        input  code,
        input  phase,
        input  ip,
        input  ibyte,
        input  tos,
        output tos_we,
        output tos_wdata
    );

endinterface

/* hdl/ej32_rstack_ram.sv */
/* dual-port stack RAM on the falling edge; read data valid in the second half
   of the cycle, a same-edge write to the read address returns the old word */
`timescale 1ns/1ns

module ej32_rstack_ram #(
    parameter type word_t = logic [31:0],   // stack payload
    parameter int  DEPTH  = 32              // entries
) (
    input  logic                     ctl,
    input  logic [$clog2(DEPTH)-1:0] rd_addr_i,
    output word_t                    rd_data_o,
    input  logic                     wr_en_i,
    input  logic [$clog2(DEPTH)-1:0] wr_addr_i,
    input  word_t                    wr_data_i
);

    word_t mem [DEPTH];                     // no init, slot 0 stays unused

    // write port, half a cycle ahead of the pointer update
    always_ff @(negedge ctl) begin
        if (wr_en_i) begin
            mem[wr_addr_i] <= wr_data_i;    // push or in-place move
        end
    end

    // registered read, seen by the caller in the same cycle
    always_ff @(negedge ctl) begin
        rd_data_o <= mem[rd_addr_i];        // top entry, reread every cycle
    end

    // pointer is owned by the caller, only the word type varies
    //   data stack or loop counters can reuse this block

endmodule

/* hdl/ej32_sequencer.sv */
/* fetch and phase sequencing; one byte per running cycle, program memory is
   read combinationally, TOS preset only while run_i is low */
`timescale 1ns/1ns

module ej32_sequencer (
    input  logic            ctl,
    input  logic            rst_i,
    input  logic            run_i,
    input  logic            tos_load_i,
    input  ej32_pkg::data_t tos_data_i,
    input  logic [7:0]      imem_data_i,
    input  ej32_pkg::addr_t br_p_i,
    input  logic            br_psel_i,
    ej32_core_if.seq        core,
    output ej32_pkg::addr_t ip_o,
    output ej32_pkg::data_t tos_o
);
    import ej32_pkg::*;

    addr_t      ip;             // instruction pointer
    opcode_t    code_r;         // latched opcode
    phase_t     phase;          // operand phase count
    data_t      tos;            // top of stack

    logic       fetch;          // opcode byte on bus
    opcode_t    code_now;       // opcode seen by the branch unit
    logic [1:0] len;            // execute phases of code_now
    phase_t     ph_inc;

    // operand bytes per opcode
    function automatic logic [1:0] op_len(input opcode_t op);
        case (op)
            goto,
            ifeq, ifne, iflt, ifge, ifgt, ifle,
            invokevirtual,
            donext:  op_len = 2'd2;     // 16-bit target
            default: op_len = 2'd0;     // single byte, incl. unknown
        endcase
    endfunction

    assign fetch    = (phase == PH_FETCH);
    assign code_now = fetch ? opcode_t'(imem_data_i) : code_r;  // decode early
    assign len      = op_len(code_now);
    assign ph_inc   = phase + 2'd1;

    // ip, opcode and phase
    always_ff @(posedge ctl) begin
        if (rst_i) begin
            ip     <= '0;
            code_r <= nop;
            phase  <= PH_FETCH;
        end
        else if (run_i) begin
            ip <= br_psel_i ? br_p_i : ip + 1'b1;   // jump or next byte
            if (fetch) begin
                code_r <= code_now;
                phase  <= (len == 2'd0) ? PH_FETCH : 2'd0;
            end
            else if (ph_inc == phase_t'(len)) begin
                phase  <= PH_FETCH;                 // last operand done
            end
            else begin
                phase  <= ph_inc;
            end
        end
    end

    // TOS, written by the branch unit or preset by the host when halted
    always_ff @(posedge ctl) begin
        if (run_i) begin
            if (core.tos_we) begin
                tos <= core.tos_wdata;              // popr / dupr
            end
        end
        else if (tos_load_i) begin
            tos <= tos_data_i;                      // host preset
        end
    end

    // to branch unit
    assign core.code  = code_now;
    assign core.phase = phase;
    assign core.ip    = ip;
    assign core.ibyte = imem_data_i;
    assign core.tos   = tos;

    // top level
    assign ip_o  = ip;
    assign tos_o = tos;

    // latched opcode must still cover the phase it is in
    a_phase_len: assert property (
        @(posedge ctl) disable iff (rst_i)
        !fetch |-> (phase < phase_t'(op_len(code_r)))
    );

endmodule

/* hdl/ej32_branch_unit.sv */
/* branch targets, conditions and return stack; br_p_o/br_psel_o are combinational
   and must be sampled at the edge, RAM data is valid only after the falling edge
   the RS pointer addresses the top entry, so at most DEPTH-1 entries are usable */
`timescale 1ns/1ns

module ej32_branch_unit (
    input  logic            ctl,
    input  logic            rst_i,
    input  logic            br_en_i,
    ej32_core_if.br         core,
    input  ej32_pkg::data_t rs_rd_data_i,
    output ej32_pkg::rsp_t  rs_rd_addr_o,
    output logic            rs_wr_en_o,
    output ej32_pkg::rsp_t  rs_wr_addr_o,
    output ej32_pkg::data_t rs_wr_data_o,
    output ej32_pkg::addr_t br_p_o,
    output logic            br_psel_o,
    output ej32_pkg::rsp_t  rdepth_o
);
    import ej32_pkg::*;

    // registers
    addr_t     a;               // operand address, high byte
    rsp_t      rp;              // RS pointer, top entry

    // next state
    addr_t     a_n;
    logic      a_x;             // load a
    addr_t     p_n;             // jump target
    logic      psel_n;          // jump this edge
    data_t     t_n;
    logic      t_x;             // TOS write
    data_t     r_n;             // RS write data
    logic      rs_wen;
    rsp_t      rp_w;            // RS write address
    stack_op_t rs_op;

    // wires
    data_t     t;               // shadow TOS
    data_t     r;               // top of RS
    logic      t_z, t_neg;      // TOS flags
    addr_t     a_d;             // merged 16-bit target
    logic      take;            // branch condition

    assign t     = core.tos;
    assign r     = rs_rd_data_i;
    assign t_z   = (t == '0);
    assign t_neg = t[$bits(data_t)-1];
    assign a_d   = {a[$bits(addr_t)-9:0], core.ibyte};   // low byte in

    // branch condition per opcode
    always_comb begin
        case (core.code)
            ifeq:                take = t_z;
            ifne:                take = !t_z;
            iflt:                take = t_neg;
            ifge:                take = !t_neg;
            ifgt:                take = !t_z && !t_neg;
            ifle:                take = t_z || t_neg;
            goto, invokevirtual: take = 1'b1;
            donext:              take = (r != '0);     // count left
            default:             take = 1'b0;
        endcase
    end

    always_comb begin
        a_n    = {{($bits(addr_t)-8){1'b0}}, core.ibyte};  // high byte
        a_x    = 1'b0;
        p_n    = a_d;
        psel_n = 1'b0;
        t_n    = r;                 // only RS feeds TOS here
        t_x    = 1'b0;
        r_n    = t;
        rs_wen = 1'b0;
        rp_w   = rp + 1'b1;         // push slot
        rs_op  = s_nop;

        // two-byte target ops
        case (core.code)
            goto, ifeq, ifne, iflt, ifge, ifgt, ifle, invokevirtual, donext: begin
                if (core.phase == 2'd0) begin
                    a_x = 1'b1;                         // latch high byte
                end
                else if (core.phase == 2'd1) begin
                    psel_n = take;                      // jump at end of phase 1
                end
            end
            default: ;
        endcase

        // return-stack side
        case (core.code)
            invokevirtual: begin
                if (core.phase == 2'd0) begin
                    r_n    = data_t'(core.ip) + data_t'(2);  // past operand
                    rs_wen = 1'b1;
                    rs_op  = s_push;
                end
            end
            donext: begin
                if (core.phase == 2'd1) begin
                    if (take) begin
                        r_n    = r - 1'b1;              // decrement in place
                        rp_w   = rp;
                        rs_wen = 1'b1;
                        rs_op  = s_move;
                    end
                    else begin
                        rs_op  = s_pop;                 // loop done
                    end
                end
            end
            jreturn: begin
                p_n    = r[$bits(addr_t)-1:0];          // return address
                psel_n = 1'b1;
                rs_op  = s_pop;
            end
            pushr: begin
                rs_wen = 1'b1;
                rs_op  = s_push;
            end
            popr: begin
                t_x   = 1'b1;
                rs_op = s_pop;
            end
            dupr:    t_x = 1'b1;
            default: ;
        endcase
    end

    // operand address, one phase deep
    always_ff @(posedge ctl) begin
        if (br_en_i && a_x) begin
            a <= a_n;
        end
    end

    // RS pointer
    always_ff @(posedge ctl) begin
        if (rst_i) begin
            rp <= '0;
        end
        else if (br_en_i) begin
            case (rs_op)
                s_push:  rp <= rp + 1'b1;
                s_pop:   rp <= rp - 1'b1;
                default: ;                              // move keeps rp
            endcase
        end
    end

    assign rs_rd_addr_o   = rp;
    assign rs_wr_en_o     = rs_wen & br_en_i;           // halted core keeps RS
    assign rs_wr_addr_o   = rp_w;
    assign rs_wr_data_o   = r_n;
    assign br_p_o         = p_n;
    assign br_psel_o      = psel_n;
    assign rdepth_o       = rp;
    assign core.tos_we    = t_x;
    assign core.tos_wdata = t_n;

    // a push must not wrap the pointer back to the unused slot
    a_rs_full: assert property (
        @(posedge ctl) disable iff (rst_i)
        br_en_i && (rs_op == s_push) |=> (rp != '0)
    );

    // a pop must not wrap below empty
    a_rs_empty: assert property (
        @(posedge ctl) disable iff (rst_i)
        br_en_i && (rs_op == s_pop) |=> (rp != '1)
    );

    // target is incomplete until the low byte arrives
    a_no_jump_ph0: assert property (
        @(posedge ctl) disable iff (rst_i)
        br_psel_o |-> (core.phase != 2'd0)
    );

endmodule

/* hdl/ej32_branch_top.sv */
/* branch slice top; program memory is external and combinational on imem_addr_o,
   run_i low freezes the core and enables the TOS preset */
`timescale 1ns/1ns
`include "ej32_settings.svh"

module ej32_branch_top (
    input  logic            ctl,
    input  logic            rst_i,
    input  logic            run_i,
    input  logic            tos_load_i,
    input  ej32_pkg::data_t tos_data_i,
    input  logic [7:0]      imem_data_i,
    output ej32_pkg::addr_t imem_addr_o,
    output ej32_pkg::data_t tos_o,
    output ej32_pkg::rsp_t  rdepth_o
);
    import ej32_pkg::*;

    ej32_core_if core ();       // sequencer <-> branch unit

    addr_t br_p;
    logic  br_psel;
    rsp_t  rs_rd_addr;
    data_t rs_rd_data;
    logic  rs_wr_en;
    rsp_t  rs_wr_addr;
    data_t rs_wr_data;

    ej32_sequencer u_seq (
        .ctl         (ctl),
        .rst_i       (rst_i),
        .run_i       (run_i),
        .tos_load_i  (tos_load_i),
        .tos_data_i  (tos_data_i),
        .imem_data_i (imem_data_i),
        .br_p_i      (br_p),
        .br_psel_i   (br_psel),
        .core        (core.seq),
        .ip_o        (imem_addr_o),
        .tos_o       (tos_o)
    );

    ej32_branch_unit u_br (
        .ctl          (ctl),
        .rst_i        (rst_i),
        .br_en_i      (run_i),      // same cadence as the sequencer
        .core         (core.br),
        .rs_rd_data_i (rs_rd_data),
        .rs_rd_addr_o (rs_rd_addr),
        .rs_wr_en_o   (rs_wr_en),
        .rs_wr_addr_o (rs_wr_addr),
        .rs_wr_data_o (rs_wr_data),
        .br_p_o       (br_p),
        .br_psel_o    (br_psel),
        .rdepth_o     (rdepth_o)
    );

    ej32_rstack_ram #(
        .word_t (data_t),
        .DEPTH  (`EJ32_RS_DEPTH)
    ) u_rs (
        .ctl       (ctl),
        .rd_addr_i (rs_rd_addr),
        .rd_data_o (rs_rd_data),
        .wr_en_i   (rs_wr_en),
        .wr_addr_i (rs_wr_addr),
        .wr_data_i (rs_wr_data)
    );

endmodule

/* verification/ej32_branch_tb.sv */
/* testbench for the branch slice; program image is a flat byte array served
   combinationally, run_i only toggles while a nop or a non-writing op is decoded
   because the return stack is written on the falling edge */
`timescale 1ns/1ns

module ej32_branch_tb;
    import ej32_pkg::*;

    localparam int WAIT_LIMIT = 200;            // cycles per wait loop

    logic       ctl;
    logic       rst;
    logic       run;
    logic       tos_load;
    data_t      tos_data;
    logic [7:0] imem_data;
    addr_t      imem_addr;
    data_t      tos;
    rsp_t       rdepth;

    logic [7:0] imem [1 << $bits(addr_t)];      // program image
    integer     seed;

    // check requests, sampled at the rising edge
    logic       chk_addr;
    logic       chk_depth;
    logic       chk_tos;
    logic       chk_visits;
    addr_t      exp_addr;
    rsp_t       exp_depth;
    data_t      exp_tos;
    int         visits;                         // fetches of the loop address
    int         exp_visits;

    ej32_branch_top u_ej32_branch_top (
        .ctl         (ctl),
        .rst_i       (rst),
        .run_i       (run),
        .tos_load_i  (tos_load),
        .tos_data_i  (tos_data),
        .imem_data_i (imem_data),
        .imem_addr_o (imem_addr),
        .tos_o       (tos),
        .rdepth_o    (rdepth)
    );

    assign imem_data = imem[imem_addr];         // async program memory

    initial begin
        ctl = 1'b0;
        forever #5 ctl = ~ctl;
    end

    task automatic stop_with(input string msg);
        $display("%s", msg);
        $display("test failed");
        $fatal(1);
    endtask

    // fresh image and reset, low and high address byte mixed into the fill
    task automatic restart();
        for (int i = 0; i < (1 << $bits(addr_t)); i++) begin
            imem[addr_t'(i)] = 8'(i) ^ 8'(i >> 8) ^ 8'h5a;
        end
        rst = 1'b1;
        run = 1'b0;
        repeat (2) @(negedge ctl);              // two rising edges in reset
        rst = 1'b0;
    endtask

    task automatic put_op(input addr_t a, input opcode_t op);
        imem[a] = op;
    endtask

    task automatic put_jump(input addr_t a, input opcode_t op, input addr_t target);
        imem[a]               = op;
        imem[addr_t'(a + 1)]  = 8'(target >> 8);  // high byte first
        imem[addr_t'(a + 2)]  = 8'(target);
    endtask

    task automatic preset_tos(input data_t v);
        tos_load = 1'b1;
        tos_data = v;
        @(negedge ctl);
        tos_load = 1'b0;
    endtask

    task automatic run_cycles(input int k);
        run = 1'b1;
        repeat (k) @(negedge ctl);
        run = 1'b0;
    endtask

    // run until the ip reaches stop, counting cycles spent at watch
    task automatic run_until_addr(input addr_t stop, input addr_t watch, output int hits);
        int n;
        n    = 0;
        hits = 0;
        run  = 1'b1;
        while (imem_addr != stop) begin
            if (imem_addr == watch) hits++;
            if (n >= WAIT_LIMIT) begin
                stop_with($sformatf("timeout, ip never reached %h", stop));
            end
            @(negedge ctl);
            n++;
        end
        run = 1'b0;
    endtask

    task automatic check_point(input addr_t a, input rsp_t d);
        exp_addr  = a;
        exp_depth = d;
        chk_addr  = 1'b1;
        chk_depth = 1'b1;
        @(negedge ctl);
        chk_addr  = 1'b0;
        chk_depth = 1'b0;
    endtask

    task automatic check_tos(input data_t v);
        exp_tos = v;
        chk_tos = 1'b1;
        @(negedge ctl);
        chk_tos = 1'b0;
    endtask

    task automatic check_visits(input int n);
        exp_visits = n;
        chk_visits = 1'b1;
        @(negedge ctl);
        chk_visits = 1'b0;
    endtask

    // zero, negative, positive or raw random TOS
    task automatic pick_tos(input int kind, output data_t v);
        v = data_t'($random(seed));
        case (kind)
            0: v = '0;
            1: v[$bits(data_t)-1] = 1'b1;
            2: begin
                v[$bits(data_t)-1] = 1'b0;
                v[0] = 1'b1;                    // strictly positive
            end
            default: ;
        endcase
    endtask

    // JVM if<cond> semantics, signed compare of TOS with zero
    function automatic logic cond_taken(input opcode_t op, input data_t v);
        case (op)
            ifeq:    cond_taken = ($signed(v) == 0);
            ifne:    cond_taken = ($signed(v) != 0);
            iflt:    cond_taken = ($signed(v) < 0);
            ifge:    cond_taken = ($signed(v) >= 0);
            ifgt:    cond_taken = ($signed(v) > 0);
            ifle:    cond_taken = ($signed(v) <= 0);
            default: cond_taken = 1'b0;
        endcase
    endfunction

    a_addr: assert property (@(posedge ctl) chk_addr |-> (imem_addr == exp_addr))
        else stop_with($sformatf("[FAIL] imem_addr_o got %h, expected %h", imem_addr, exp_addr));

    a_depth: assert property (@(posedge ctl) chk_depth |-> (rdepth == exp_depth))
        else stop_with($sformatf("[FAIL] rdepth_o got %h, expected %h", rdepth, exp_depth));

    a_tos: assert property (@(posedge ctl) chk_tos |-> (tos == exp_tos))
        else stop_with($sformatf("[FAIL] tos_o got %h, expected %h", tos, exp_tos));

    a_visits: assert property (@(posedge ctl) chk_visits |-> (visits == exp_visits))
        else stop_with($sformatf("[FAIL] visits got %h, expected %h", visits, exp_visits));

    initial begin
        opcode_t op;
        data_t   v;
        data_t   w;
        int      n;

        seed       = 40878;
        rst        = 1'b1;
        run        = 1'b0;
        tos_load   = 1'b0;
        tos_data   = '0;
        chk_addr   = 1'b0;
        chk_depth  = 1'b0;
        chk_tos    = 1'b0;
        chk_visits = 1'b0;
        exp_addr   = '0;
        exp_depth  = '0;
        exp_tos    = '0;
        visits     = 0;
        exp_visits = 0;

        // reset state, entered from ip 2 with one RS entry
        restart();
        put_op(16'h0000, nop);
        put_op(16'h0001, pushr);
        run_cycles(2);
        restart();
        check_point(16'h0000, 5'd0);

        // goto lands 3 running cycles after the opcode fetch
        restart();
        put_jump(16'h0000, goto, 16'h0040);
        put_op(16'h0040, nop);
        run_cycles(3);
        check_point(16'h0040, 5'd0);

        // six conditional branches, four TOS classes each
        op = ifeq;
        for (int i = 0; i < 6; i++) begin
            for (int k = 0; k < 4; k++) begin
                pick_tos(k, v);
                restart();
                put_jump(16'h0000, op, 16'h1a5c);
                put_op(16'h1a5c, nop);
                put_op(16'h0003, nop);          // fall-through slot
                preset_tos(v);
                run_cycles(3);
                check_point(cond_taken(op, v) ? 16'h1a5c : 16'h0003, 5'd0);
            end
            op = op.next();
        end

        // call from 0020 into a jreturn at 0050
        restart();
        put_jump(16'h0000, goto, 16'h0020);
        put_jump(16'h0020, invokevirtual, 16'h0050);
        put_op(16'h0023, nop);
        put_op(16'h0050, jreturn);
        run_cycles(3);
        check_point(16'h0020, 5'd0);
        run_cycles(3);
        check_point(16'h0050, 5'd1);
        run_until_addr(16'h0023, 16'h0050, visits);
        check_point(16'h0023, 5'd0);

        // donext loop on itself, first pass plus n revisits
        for (int j = 0; j < 2; j++) begin
            n = (j == 0) ? 0 : ($random(seed) & 7) + 1;
            restart();
            put_op(16'h0000, nop);
            put_op(16'h0001, pushr);
            put_jump(16'h0002, donext, 16'h0002);
            put_op(16'h0005, nop);
            preset_tos(data_t'(n));
            run_until_addr(16'h0005, 16'h0002, visits);
            check_visits(n + 1);
            check_point(16'h0005, 5'd0);
        end

        // pushr, dupr and popr move v between TOS and the return stack
        restart();
        put_op(16'h0000, nop);
        put_op(16'h0001, pushr);
        put_op(16'h0002, dupr);
        put_op(16'h0003, popr);
        put_op(16'h0004, nop);
        pick_tos(3, v);
        w = ~v;
        preset_tos(v);
        run_cycles(2);
        check_point(16'h0002, 5'd1);
        preset_tos(w);
        check_tos(w);
        run_cycles(1);                          // dupr
        check_tos(v);
        check_point(16'h0003, 5'd1);
        preset_tos(w);
        run_cycles(1);                          // popr
        check_tos(v);
        check_point(16'h0004, 5'd0);

        $display("test passed");
        $finish;
    end

endmodule

/* ej32_branch.f */
+incdir+hdl
hdl/ej32_pkg.sv
hdl/ej32_core_if.sv
hdl/ej32_rstack_ram.sv
hdl/ej32_sequencer.sv
hdl/ej32_branch_unit.sv
hdl/ej32_branch_top.sv
verification/ej32_branch_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the ej32 branch slice testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --assert -j 0 -f ej32_branch.f --top-module ej32_branch_tb

# a failing run exits non-zero, so keep the output and decide below
out=$(./obj_dir/Vej32_branch_tb 2>&1) || true
echo "$out"

if echo "$out" | grep -qx "test passed"; then
    exit 0
fi
exit 1
